// File: rtl/nes_timing_pkg.sv
`default_nettype none

package nes_timing_pkg;

	// Master clock divider, NTSC ratio
	localparam int unsigned cpu_div_w = 5;                  // Wide enough to count to 12
	localparam logic [cpu_div_w-1:0] cpu_div_n = 5'd12;     // Master clocks per CPU cycle

	// Sprite DMA state
	// Bit 0 set means the CPU is held off
	// Bit 1 set means read/write pairs are running
	typedef enum logic [1:0] {
		spr_idle       = 2'd0,  // No transfer
		spr_wait_align = 2'd1,  // Stalled, waiting for a get cycle with CPU reading
		spr_run        = 2'd3   // Transfer in progress
	} spr_state_t;

endpackage

`default_nettype wire

// File: rtl/nes_bus_pkg.sv
`default_nettype none

package nes_bus_pkg;

	localparam int unsigned addr_w = 16;    // CPU address bus
	localparam int unsigned data_w = 8;     // CPU data bus

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [data_w-1:0] data_t;

	// Register window $4000-$401F, 32 registers
	localparam int unsigned io_off_w = 5;
	localparam logic [addr_w-io_off_w-1:0] io_base_hi = 11'b0100_0000_000;

	// Register offsets inside the window
	localparam logic [io_off_w-1:0] oam_dma_reg = 5'h14;   // Sprite DMA page
	localparam logic [io_off_w-1:0] joy1_reg    = 5'h16;   // Joypad 1, strobe on write
	localparam logic [io_off_w-1:0] joy2_reg    = 5'h17;   // Joypad 2

	// PPU OAM data port, target of every sprite DMA write
	localparam addr_t oam_data_addr = 16'h2004;

	// Joypad serial data lines
	localparam int unsigned joy_data_w = 5;

	// Sprite DMA source address split into page and offset
	typedef struct packed {
		data_t page;    // Written by the CPU to $4014
		data_t offset;  // Counts 00..FF
	} spr_page_off_t;

	// Same 16 bits, seen either as a bus address or as page/offset
	typedef union packed {
		addr_t         full;
		spr_page_off_t po;
	} spr_addr_u;

endpackage

`default_nettype wire

// File: rtl/dma_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// DMA engine as bus master toward the arbiter
interface dma_bus_if;

	nes_bus_pkg::addr_t addr;     // Address the DMA wants to access
	logic               enable;   // DMA owns the bus
	logic               read;     // 1 = read, 0 = write
	nes_bus_pkg::data_t wdata;    // Write data from the DMA latch
	nes_bus_pkg::data_t rdata;    // Internal data bus this clock

	// No handshake, the arbiter follows enable in the same clock
	modport master (
		output addr, enable, read, wdata,
		input  rdata
	);

	modport arbiter (
		input  addr, enable, read, wdata,
		output rdata
	);

endinterface

`default_nettype wire

// File: rtl/cycle_divider.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_divider (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,     // One master clock per CPU cycle
	output logic put_cycle,  // 1 = odd (put), 0 = even (get)
	output logic get_ce,
	output logic put_ce
);

	typedef logic [nes_timing_pkg::cpu_div_w-1:0] div_cnt_t;

	div_cnt_t div_cnt;       // Runs 1..12
	logic     odd_or_even;

	// CE on the last master clock of the CPU cycle
	assign cpu_ce = (div_cnt == nes_timing_pkg::cpu_div_n);

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= div_cnt_t'(1);
		end else if (cpu_ce) begin
			div_cnt <= div_cnt_t'(1);   // Wrap, start next CPU cycle
		end else begin
			div_cnt <= div_cnt + div_cnt_t'(1);
		end
	end

	// First CPU cycle after reset is odd
	always_ff @(posedge clk) begin
		if (reset)
			odd_or_even <= 1'b1;
		else if (cpu_ce)
			odd_or_even <= ~odd_or_even;
	end

	assign put_cycle = odd_or_even;

	// Split the CE by cycle parity
	assign get_ce = cpu_ce & ~odd_or_even;  // Even, DMA reads here
	assign put_ce = cpu_ce & odd_or_even;   // Odd, DMA writes here

endmodule

`default_nettype wire

// File: rtl/cpu_io_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_io_decode (
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic                                     cpu_ce,
	input  logic                                     put_ce,
	input  nes_bus_pkg::addr_t                       cpu_addr,
	input  logic                                     cpu_rnw,
	input  nes_bus_pkg::data_t                       cpu_dout,
	output logic                                     sprite_trigger,  // Write to $4014
	output logic                                     joy1_sel,
	output logic                                     joy2_sel,
	output logic [2:0]                               joypad_out,
	output logic [1:0]                               joypad_clock
);

	localparam int unsigned off_w = nes_bus_pkg::io_off_w;

	logic             io_cs;     // Inside $4000-$401F
	logic [off_w-1:0] io_off;
	logic             joy_wr;    // CPU write to $4016 this clock
	logic [2:0]       joy_latch; // Strobe value written by the CPU
	logic [2:0]       joy_out_q;

	assign io_cs  = (cpu_addr[nes_bus_pkg::addr_w-1:off_w] == nes_bus_pkg::io_base_hi);
	assign io_off = cpu_addr[off_w-1:0];

	assign joy1_sel = io_cs && (io_off == nes_bus_pkg::joy1_reg);
	assign joy2_sel = io_cs && (io_off == nes_bus_pkg::joy2_reg);

	// Page register write, only real on the CE clock
	assign sprite_trigger = io_cs && (io_off == nes_bus_pkg::oam_dma_reg) && !cpu_rnw && cpu_ce;

	// Reads shift the pads, one pulse per CPU read
	assign joypad_clock = {joy2_sel && cpu_rnw && cpu_ce, joy1_sel && cpu_rnw && cpu_ce};

	assign joy_wr = joy1_sel && !cpu_rnw && cpu_ce;

	// Strobe lines follow the latch on put cycles only
	always_ff @(posedge clk) begin
		if (reset) begin
			joy_latch <= 3'b000;
			joy_out_q <= 3'b000;
		end else begin
			if (put_ce)
				joy_out_q <= joy_latch;
			if (joy_wr) begin
				joy_latch <= cpu_dout[2:0];
				if (put_ce)
					joy_out_q <= cpu_dout[2:0];   // Write on a put cycle goes straight out
			end
		end
	end

	assign joypad_out = joy_out_q;

endmodule

`default_nettype wire

// File: rtl/oam_dmc_dma.sv
`timescale 1ns/1ps
`default_nettype none

// Sprite DMA reads on get cycles and writes $2004 on put cycles
// DMC takes a get cycle, the sprite read at that offset moves to the next get
module oam_dmc_dma (
	input  logic               clk,
	input  logic               reset,
	input  logic               cpu_ce,
	input  logic               put_cycle,
	input  logic               get_ce,
	input  logic               put_ce,
	input  logic               sprite_trigger,
	input  logic               cpu_rnw,        // CPU in a read cycle
	input  nes_bus_pkg::data_t cpu_dout,       // Page number on trigger
	input  logic               dmc_request,
	input  nes_bus_pkg::addr_t dmc_addr,
	output logic               dmc_ack,
	output logic               pause_cpu,
	dma_bus_if.master          dma
);

	logic                       dmc_pend;   // DMC slot granted, ack on next get
	nes_timing_pkg::spr_state_t spr_state;
	nes_bus_pkg::spr_addr_u     spr_addr;
	nes_bus_pkg::data_t         spr_data;   // Byte read, waiting for $2004
	logic                       spr_full;   // spr_data holds an unwritten byte
	logic                       dmc_sel;    // DMC owns this get cycle
	logic                       spr_go;     // Sprite may read on a get cycle
	logic                       spr_rd;     // Sprite read this cycle

	// DMC read needs the request still up, it may drop early
	assign dmc_sel = dmc_pend && !put_cycle && dmc_request;

	// Waiting state joins as soon as the CPU sits in a read cycle
	assign spr_go = spr_state[1] ||
		(spr_state == nes_timing_pkg::spr_wait_align && cpu_rnw);
	assign spr_rd = spr_go && !put_cycle && !dmc_sel;

	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_pend  <= 1'b0;
			spr_state <= nes_timing_pkg::spr_idle;
			spr_full  <= 1'b0;
		end else if (cpu_ce) begin
			// DMC arbitration happens on put cycles
			if (!dmc_pend && dmc_request && cpu_rnw && put_ce)
				dmc_pend <= 1'b1;
			else if (dmc_pend && put_ce)
				dmc_pend <= 1'b0;   // Slot used or request withdrawn

			if (sprite_trigger) begin
				spr_state <= nes_timing_pkg::spr_wait_align;
			end else if (spr_rd && get_ce) begin
				if (&spr_addr.po.offset)
					spr_state <= nes_timing_pkg::spr_idle;   // Last read, write still due
				else
					spr_state <= nes_timing_pkg::spr_run;
			end

			// Byte pending from the get cycle is written on the put cycle
			if (spr_rd && get_ce)
				spr_full <= 1'b1;
			else if (put_ce)
				spr_full <= 1'b0;
		end
	end

	// Source address, page from the CPU and offset counted per read
	always_ff @(posedge clk) begin
		if (sprite_trigger) begin
			spr_addr.po.page   <= cpu_dout;
			spr_addr.po.offset <= '0;
		end else if (spr_rd && get_ce) begin
			spr_addr.po.offset <= spr_addr.po.offset + 1'b1;
		end
	end

	// Follow the bus for the whole read cycle, last value at CE sticks
	always_ff @(posedge clk) begin
		if (spr_rd)
			spr_data <= dma.rdata;
	end

	assign pause_cpu = spr_state[0] || spr_full || dmc_request || dmc_pend;

	assign dmc_ack = dmc_sel && cpu_ce;   // Single clock, on the get CE

	assign dma.enable = dmc_sel || spr_rd || (spr_full && put_cycle);
	assign dma.read   = !put_cycle;
	assign dma.wdata  = spr_data;
	assign dma.addr   = dmc_sel    ? dmc_addr :
		!put_cycle ? spr_addr.full :
		nes_bus_pkg::oam_data_addr;

endmodule

`default_nettype wire

// File: rtl/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  cpu_ce,
	input  nes_bus_pkg::addr_t                    cpu_addr,
	input  logic                                  cpu_rnw,
	input  nes_bus_pkg::data_t                    cpu_dout,
	input  logic                                  joy1_sel,
	input  logic                                  joy2_sel,
	input  logic [nes_bus_pkg::joy_data_w-1:0]    joypad1_data,
	input  logic [nes_bus_pkg::joy_data_w-1:0]    joypad2_data,
	input  nes_bus_pkg::data_t                    mem_din,
	output nes_bus_pkg::addr_t                    mem_addr,
	output logic                                  mem_read,
	output logic                                  mem_write,
	output nes_bus_pkg::data_t                    mem_dout,
	output nes_bus_pkg::data_t                    cpu_din,
	dma_bus_if.arbiter                            dma
);

	localparam int unsigned data_w = nes_bus_pkg::data_w;
	localparam int unsigned joy_w  = nes_bus_pkg::joy_data_w;
	localparam int unsigned off_w  = nes_bus_pkg::io_off_w;

	nes_bus_pkg::addr_t bus_addr;
	nes_bus_pkg::data_t bus_wdata;
	nes_bus_pkg::data_t rd_data;    // Internal data bus
	nes_bus_pkg::data_t open_bus;   // Last value seen on the bus
	logic               bus_rd;
	logic               io_cs;

	// DMA wins whenever it asks
	assign bus_addr  = dma.enable ? dma.addr  : cpu_addr;
	assign bus_rd    = dma.enable ? dma.read  : cpu_rnw;
	assign bus_wdata = dma.enable ? dma.wdata : cpu_dout;

	// Internal registers never reach the external memory
	assign io_cs = (bus_addr[nes_bus_pkg::addr_w-1:off_w] == nes_bus_pkg::io_base_hi);

	assign mem_addr  = bus_addr;
	assign mem_dout  = bus_wdata;
	assign mem_read  = cpu_ce && bus_rd && !io_cs;
	assign mem_write = cpu_ce && !bus_rd && !io_cs;

	// Pads only drive the low bits, the rest floats at open bus
	always_comb begin
		if (joy1_sel && !dma.enable)
			rd_data = {open_bus[data_w-1:joy_w], joypad1_data};
		else if (joy2_sel && !dma.enable)
			rd_data = {open_bus[data_w-1:joy_w], joypad2_data};
		else if (!io_cs)
			rd_data = mem_din;      // Memory read
		else
			rd_data = open_bus;     // Unused register
	end

	// Bus capacitance, holds whoever drove it last
	always_ff @(posedge clk) begin
		if (reset)
			open_bus <= '0;
		else if (!cpu_ce)
			open_bus <= bus_rd ? rd_data : bus_wdata;
	end

	assign cpu_din   = rd_data;
	assign dma.rdata = rd_data;

endmodule

`default_nettype wire

// File: rtl/nes_dma_top.sv
`timescale 1ns/1ps
`default_nettype none

// CPU side of the 2A03 without the core, APU and PPU
module nes_dma_top (
	input  logic                                clk,
	input  logic                                reset,

	// External 6502 core
	input  nes_bus_pkg::addr_t                  cpu_addr,
	input  logic                                cpu_rnw,
	input  nes_bus_pkg::data_t                  cpu_dout,
	output nes_bus_pkg::data_t                  cpu_din,
	output logic                                cpu_ce,
	output logic                                pause_cpu,

	// DMC sample fetch
	input  logic                                dmc_request,
	input  nes_bus_pkg::addr_t                  dmc_addr,
	output logic                                dmc_ack,
	output nes_bus_pkg::data_t                  dmc_data,

	// Memory bus
	output nes_bus_pkg::addr_t                  mem_addr,
	output logic                                mem_read,
	output logic                                mem_write,
	output nes_bus_pkg::data_t                  mem_dout,
	input  nes_bus_pkg::data_t                  mem_din,

	// Joypads
	input  logic [nes_bus_pkg::joy_data_w-1:0]  joypad1_data,
	input  logic [nes_bus_pkg::joy_data_w-1:0]  joypad2_data,
	output logic [2:0]                          joypad_out,
	output logic [1:0]                          joypad_clock
);

	logic put_cycle;
	logic get_ce;
	logic put_ce;
	logic sprite_trigger;
	logic joy1_sel;
	logic joy2_sel;

	dma_bus_if dma_bus ();

	cycle_divider cycle_divider_i (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.put_cycle (put_cycle),
		.get_ce    (get_ce),
		.put_ce    (put_ce)
	);

	cpu_io_decode cpu_io_decode_i (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.put_ce         (put_ce),
		.cpu_addr       (cpu_addr),
		.cpu_rnw        (cpu_rnw),
		.cpu_dout       (cpu_dout),
		.sprite_trigger (sprite_trigger),
		.joy1_sel       (joy1_sel),
		.joy2_sel       (joy2_sel),
		.joypad_out     (joypad_out),
		.joypad_clock   (joypad_clock)
	);

	oam_dmc_dma oam_dmc_dma_i (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.put_cycle      (put_cycle),
		.get_ce         (get_ce),
		.put_ce         (put_ce),
		.sprite_trigger (sprite_trigger),
		.cpu_rnw        (cpu_rnw),
		.cpu_dout       (cpu_dout),
		.dmc_request    (dmc_request),
		.dmc_addr       (dmc_addr),
		.dmc_ack        (dmc_ack),
		.pause_cpu      (pause_cpu),
		.dma            (dma_bus.master)
	);

	bus_arbiter bus_arbiter_i (
		.clk          (clk),
		.reset        (reset),
		.cpu_ce       (cpu_ce),
		.cpu_addr     (cpu_addr),
		.cpu_rnw      (cpu_rnw),
		.cpu_dout     (cpu_dout),
		.joy1_sel     (joy1_sel),
		.joy2_sel     (joy2_sel),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data),
		.mem_din      (mem_din),
		.mem_addr     (mem_addr),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_dout     (mem_dout),
		.cpu_din      (cpu_din),
		.dma          (dma_bus.arbiter)
	);

	// Sample byte comes off the internal bus on the ack clock
	assign dmc_data = dma_bus.rdata;

endmodule

`default_nettype wire

// File: verif/tb_nes_dma.sv
`timescale 1ns/1ps
`default_nettype none

module tb_nes_dma;

	typedef nes_bus_pkg::addr_t addr_t;
	typedef nes_bus_pkg::data_t data_t;

	// 1200 CPU cycles of 12 master clocks cover every test
	localparam int watchdog_ns = 12 * 1200 * 100;

	logic clk;
	logic reset;
	addr_t cpu_addr;
	logic cpu_rnw;
	data_t cpu_dout;
	data_t cpu_din;
	logic cpu_ce;
	logic pause_cpu;
	logic dmc_request;
	addr_t dmc_addr;
	logic dmc_ack;
	data_t dmc_data;
	addr_t mem_addr;
	logic mem_read;
	logic mem_write;
	data_t mem_dout;
	data_t mem_din;
	logic [4:0] joypad1_data;
	logic [4:0] joypad2_data;
	logic [2:0] joypad_out;
	logic [1:0] joypad_clock;

	logic [31:0] rng = 32'd78;    // xorshift state
	addr_t wr_log_addr[$];        // Every memory write in order
	data_t wr_log_data[$];
	int clks_since_ce;
	int dmc_acks;
	int spr_reads;
	int spr_writes;
	logic spr_active;             // Sprite DMA window under check
	logic prev_spr_rd;            // Last cpu_ce was a sprite read
	data_t spr_page;
	addr_t last_rd_addr;
	logic ce_mem_read;            // Sampled on the CPU access CE
	logic [1:0] ce_joypad_clock;
	logic exp_put;                // Coming cpu_ce is a put cycle

	nes_dma_top nes_dma_top_i (.*);

	// Memory content is the low byte xor the high byte
	function automatic data_t mem_model(input addr_t a);
		return a[7:0] ^ a[15:8];
	endfunction

	assign mem_din = mem_model(mem_addr);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic stop_with_failure();
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		$display("[FAIL] t=%0t %s expected %0h actual %0h", $time, sig, exp_v, act_v);
		stop_with_failure();
	endtask

	task automatic report_problem(input string what);
		$display("ERROR t=%0t %s", $time, what);
		stop_with_failure();
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;  // 100 ns period
	end

	initial begin
		#(watchdog_ns);
		$display("ERROR the run did not finish within %0d ns", watchdog_ns);
		stop_with_failure();
	end

	// First CPU cycle after reset is odd, parity flips on every cpu_ce
	always @(posedge clk) begin
		if (reset)
			exp_put <= 1'b1;
		else if (cpu_ce)
			exp_put <= ~exp_put;
	end

	assert property (@(posedge clk) disable iff (reset) dmc_request |-> pause_cpu)
		else report_mismatch("pause_cpu", 1, 0);
	assert property (@(posedge clk) disable iff (reset) !cpu_ce |-> !mem_read && !mem_write)
		else report_problem("memory strobe outside cpu_ce");
	assert property (@(posedge clk) disable iff (reset)
		dmc_ack |-> cpu_ce && !exp_put && mem_read)
		else report_problem("dmc_ack not on a get cycle memory read");

	// Bus monitor samples outputs at the rising edge
	always @(posedge clk) begin
		if (reset) begin
			clks_since_ce = 0;
		end else begin
			clks_since_ce++;
			if (cpu_ce) begin
				assert (clks_since_ce == 12) else report_mismatch("cpu_ce period", 12, clks_since_ce);
				clks_since_ce = 0;
				if (mem_write) begin
					wr_log_addr.push_back(mem_addr);
					wr_log_data.push_back(mem_dout);
				end
				if (dmc_ack) begin
					assert (mem_addr == dmc_addr) else report_mismatch("mem_addr", dmc_addr, mem_addr);
					assert (dmc_data == mem_model(dmc_addr))
						else report_mismatch("dmc_data", mem_model(dmc_addr), dmc_data);
					dmc_acks++;
				end
				if (spr_active) begin
					if (prev_spr_rd) begin   // Write of the byte just read
						assert (mem_write) else report_mismatch("mem_write", 1, mem_write);
						assert (mem_addr == nes_bus_pkg::oam_data_addr)
							else report_mismatch("mem_addr", nes_bus_pkg::oam_data_addr, mem_addr);
						assert (mem_dout == mem_model(last_rd_addr))
							else report_mismatch("mem_dout", mem_model(last_rd_addr), mem_dout);
						spr_writes++;
					end else begin
						assert (!mem_write) else report_mismatch("mem_write", 0, mem_write);
					end
					if (mem_read && !dmc_ack) begin
						assert (spr_reads < 256) else report_problem("more than 256 sprite reads");
						assert (mem_addr == {spr_page, spr_reads[7:0]})
							else report_mismatch("mem_addr", {spr_page, spr_reads[7:0]}, mem_addr);
						assert (pause_cpu) else report_mismatch("pause_cpu", 1, pause_cpu);
						last_rd_addr = mem_addr;
						spr_reads++;
					end
					prev_spr_rd = mem_read && !dmc_ack;
				end
			end
		end
	end

	// One CPU access held until a cpu_ce without stall
	task automatic cpu_access(input addr_t a, input logic rnw, input data_t d, output data_t q);
		cpu_addr = a;
		cpu_rnw = rnw;
		cpu_dout = d;
		do begin
			@(posedge clk);
		end while (!(cpu_ce && !pause_cpu));
		q = cpu_din;
		ce_mem_read = mem_read;
		ce_joypad_clock = joypad_clock;
		#5;
	endtask

	task automatic dmc_fetch(input addr_t a);
		dmc_addr = a;
		dmc_request = 1'b1;
		do begin
			@(posedge clk);
		end while (!dmc_ack);
		#5;
		dmc_request = 1'b0;   // Held exactly until the ack
	endtask

	task automatic run_sprite_dma(input data_t page, input logic with_dmc, input addr_t dmc_a);
		data_t q;
		int acks_before;
		acks_before = dmc_acks;
		spr_page = page;
		spr_reads = 0;
		spr_writes = 0;
		prev_spr_rd = 1'b0;
		spr_active = 1'b1;
		cpu_access(16'h4014, 1'b0, page, q);
		cpu_addr = 16'h4000;   // Halted CPU parks on a dummy read
		cpu_rnw = 1'b1;
		if (with_dmc) begin
			do begin
				@(posedge clk);
			end while (spr_reads < 40);
			#5;
			dmc_fetch(dmc_a);
		end
		cpu_access(16'h4000, 1'b1, 8'h00, q);   // Returns after pause_cpu falls
		spr_active = 1'b0;
		assert (spr_reads == 256) else report_mismatch("sprite reads", 256, spr_reads);
		assert (spr_writes == 256) else report_mismatch("sprite writes", 256, spr_writes);
		assert (dmc_acks == acks_before + int'(with_dmc))
			else report_mismatch("dmc_ack count", acks_before + int'(with_dmc), dmc_acks);
	endtask

	initial begin
		data_t q;
		data_t v;
		int acks;
		reset = 1'b1;
		cpu_addr = 16'h4000;
		cpu_rnw = 1'b1;
		cpu_dout = 8'h00;
		dmc_request = 1'b0;
		dmc_addr = 16'h8000;
		joypad1_data = 5'h00;
		joypad2_data = 5'h00;
		spr_active = 1'b0;
		prev_spr_rd = 1'b0;
		dmc_acks = 0;
		repeat (2) @(posedge clk);
		#5 reset = 1'b0;

		assert (!pause_cpu) else report_mismatch("pause_cpu", 0, pause_cpu);
		assert (!dmc_ack) else report_mismatch("dmc_ack", 0, dmc_ack);
		assert (!mem_write) else report_mismatch("mem_write", 0, mem_write);
		assert (joypad_clock == 2'b00) else report_mismatch("joypad_clock", 0, joypad_clock);
		assert (joypad_out == 3'b000) else report_mismatch("joypad_out", 0, joypad_out);
		rng = xorshift32(rng);
		joypad1_data = rng[4:0];
		joypad2_data = rng[9:5];

		rng = xorshift32(rng);
		run_sprite_dma({3'b000, rng[4:0]}, 1'b0, 16'h8000);

		// DMC fetch with the CPU idle
		rng = xorshift32(rng);
		acks = dmc_acks;
		cpu_access(16'h4000, 1'b1, 8'h00, q);
		dmc_fetch({1'b1, rng[14:0]});
		cpu_access(16'h4000, 1'b1, 8'h00, q);
		assert (dmc_acks == acks + 1) else report_mismatch("dmc_ack count", acks + 1, dmc_acks);

		rng = xorshift32(rng);
		run_sprite_dma({3'b000, rng[4:0]}, 1'b1, {1'b1, rng[22:8]});

		// Strobe reaches the pads on a put cycle
		rng = xorshift32(rng);
		v = rng[7:0];
		cpu_access(16'h4016, 1'b0, v, q);
		cpu_access(16'h4000, 1'b1, 8'h00, q);
		@(posedge clk);
		#5;
		assert (joypad_out == v[2:0]) else report_mismatch("joypad_out", v[2:0], joypad_out);

		v = {3'b101, rng[12:8]};   // Upper bits set so open bus shows through
		cpu_access(16'h0123, 1'b0, v, q);
		cpu_access(16'h4017, 1'b1, 8'h00, q);
		assert (ce_joypad_clock == 2'b10) else report_mismatch("joypad_clock", 2'b10, ce_joypad_clock);
		assert (q == {v[7:5], joypad2_data}) else report_mismatch("cpu_din", {v[7:5], joypad2_data}, q);

		// Unused register returns the last bus value
		v = rng[23:16];
		cpu_access(16'h0200, 1'b0, v, q);
		assert (wr_log_addr[$] == 16'h0200 && wr_log_data[$] == v)
			else report_problem("RAM write missing from the write log");
		cpu_access(16'h4000, 1'b1, 8'h00, q);
		assert (!ce_mem_read) else report_mismatch("mem_read", 0, ce_mem_read);
		assert (q == v) else report_mismatch("cpu_din", v, q);
		cpu_access(16'h0345, 1'b1, 8'h00, q);
		assert (q == mem_model(16'h0345)) else report_mismatch("cpu_din", mem_model(16'h0345), q);
		cpu_access(16'h4000, 1'b1, 8'h00, q);
		assert (q == mem_model(16'h0345)) else report_mismatch("cpu_din", mem_model(16'h0345), q);

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
rtl/nes_timing_pkg.sv
rtl/nes_bus_pkg.sv
rtl/dma_bus_if.sv
rtl/cycle_divider.sv
rtl/cpu_io_decode.sv
rtl/oam_dmc_dma.sv
rtl/bus_arbiter.sv
rtl/nes_dma_top.sv
verif/tb_nes_dma.sv

// File: Bender.yml
package:
  name: nes_dma

sources:
  - rtl/nes_timing_pkg.sv
  - rtl/nes_bus_pkg.sv
  - rtl/dma_bus_if.sv
  - rtl/cycle_divider.sv
  - rtl/cpu_io_decode.sv
  - rtl/oam_dmc_dma.sv
  - rtl/bus_arbiter.sv
  - rtl/nes_dma_top.sv
  - target: test
    files:
      - verif/tb_nes_dma.sv
